// File: logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;   // bits 31:26
    typedef logic [5:0]  funct_t;    // bits 5:0
    typedef logic [4:0]  shamt_t;    // bits 10:6, also a variable shift count
    typedef logic [15:0] imm16_t;    // bits 15:0

    // major opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // function codes under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

endpackage

`default_nettype wire

// File: logic/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation inside a result group
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_OR   = 4'd1,
        OP_AND  = 4'd2,
        OP_XOR  = 4'd3,
        OP_NOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_ADD  = 4'd8,
        OP_SUB  = 4'd9,
        OP_SLT  = 4'd10,
        OP_SLTU = 4'd11,
        OP_MOVN = 4'd12,
        OP_MOVZ = 4'd13
    } alu_op_e;

    // result group picked in execute
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_LOGIC = 3'd1,
        SEL_SHIFT = 3'd2,
        SEL_ARITH = 3'd3,
        SEL_MOVE  = 3'd4
    } alu_sel_e;

endpackage

`default_nettype wire

// File: logic/regfile.sv
`default_nettype none

module regfile (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           we_i,
    input  wire core_ctrl_pkg::reg_addr_t waddr_i,
    input  wire core_ctrl_pkg::word_t     wdata_i,
    input  wire core_ctrl_pkg::reg_addr_t raddr1_i,
    input  wire core_ctrl_pkg::reg_addr_t raddr2_i,
    output core_ctrl_pkg::word_t          rdata1_o,
    output core_ctrl_pkg::word_t          rdata2_o
);
    import core_ctrl_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero, same-cycle write passes through
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

    // decode drops r0 writes three stages upstream
    a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire mips_isa_pkg::inst_t      inst_i,
    input  wire core_ctrl_pkg::word_t     rf_rdata1_i,
    input  wire core_ctrl_pkg::word_t     rf_rdata2_i,
    input  wire                           ex_we_i,
    input  wire core_ctrl_pkg::reg_addr_t ex_waddr_i,
    input  wire core_ctrl_pkg::word_t     ex_wdata_i,
    input  wire                           mem_we_i,
    input  wire core_ctrl_pkg::reg_addr_t mem_waddr_i,
    input  wire core_ctrl_pkg::word_t     mem_wdata_i,
    output core_ctrl_pkg::reg_addr_t      rf_raddr1_o,
    output core_ctrl_pkg::reg_addr_t      rf_raddr2_o,
    output core_ctrl_pkg::alu_op_e        aluop_o,
    output core_ctrl_pkg::alu_sel_e       alusel_o,
    output core_ctrl_pkg::word_t          opnd1_o,
    output core_ctrl_pkg::word_t          opnd2_o,
    output core_ctrl_pkg::reg_addr_t      waddr_o,
    output logic                          we_o
);
    import mips_isa_pkg::*;
    import core_ctrl_pkg::*;

    inst_t     inst_q;     // fetch register
    opcode_t   op;
    funct_t    fn;
    shamt_t    sa;
    imm16_t    imm16;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic      shift_imm;  // sll/srl/sra form
    logic      re1;
    logic      re2;
    logic      move_ok;
    word_t     imm;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_q <= '0;
        end else begin
            inst_q <= inst_i;
        end
    end

    assign op        = inst_q[31:26];
    assign rs        = inst_q[25:21];
    assign rt        = inst_q[20:16];
    assign rd        = inst_q[15:11];
    assign sa        = inst_q[10:6];
    assign fn        = inst_q[5:0];
    assign imm16     = inst_q[15:0];
    assign shift_imm = fn inside {FN_SLL, FN_SRL, FN_SRA};

    assign rf_raddr1_o = rs;
    assign rf_raddr2_o = rt;

    always_comb begin
        aluop_o = OP_NOP;
        re1     = 1'b1;
        re2     = 1'b0;
        waddr_o = rt;                       // i-type target
        imm     = {{16{imm16[15]}}, imm16};
        case (op)
            OP_SPECIAL: begin
                re2     = 1'b1;
                waddr_o = rd;
                if (shift_imm ? (rs == '0) : (sa == '0)) begin
                    case (fn)
                        FN_OR:           aluop_o = OP_OR;
                        FN_AND:          aluop_o = OP_AND;
                        FN_XOR:          aluop_o = OP_XOR;
                        FN_NOR:          aluop_o = OP_NOR;
                        FN_SLL, FN_SLLV: aluop_o = OP_SLL;
                        FN_SRL, FN_SRLV: aluop_o = OP_SRL;
                        FN_SRA, FN_SRAV: aluop_o = OP_SRA;
                        FN_ADD, FN_ADDU: aluop_o = OP_ADD;
                        FN_SUB, FN_SUBU: aluop_o = OP_SUB;
                        FN_SLT:          aluop_o = OP_SLT;
                        FN_SLTU:         aluop_o = OP_SLTU;
                        FN_MOVN:         aluop_o = OP_MOVN;
                        FN_MOVZ:         aluop_o = OP_MOVZ;
                        default:         aluop_o = OP_NOP;
                    endcase
                end
                if (shift_imm) begin
                    re1 = 1'b0;             // sa stands in for rs
                    imm = word_t'(sa);
                end
            end
            OP_ORI: begin
                aluop_o    = OP_OR;
                imm[31:16] = '0;
            end
            OP_ANDI: begin
                aluop_o    = OP_AND;
                imm[31:16] = '0;
            end
            OP_XORI: begin
                aluop_o    = OP_XOR;
                imm[31:16] = '0;
            end
            OP_LUI: begin
                aluop_o = OP_OR;            // imm | imm
                re1     = 1'b0;
                imm     = {imm16, 16'b0};
            end
            OP_SLTI:           aluop_o = OP_SLT;
            OP_SLTIU:          aluop_o = OP_SLTU;  // unsigned compare of sext imm
            OP_ADDI, OP_ADDIU: aluop_o = OP_ADD;   // no overflow trap
            default:           aluop_o = OP_NOP;
        endcase
    end

    always_comb begin
        case (aluop_o)
            OP_OR, OP_AND, OP_XOR, OP_NOR:   alusel_o = SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:          alusel_o = SEL_SHIFT;
            OP_ADD, OP_SUB, OP_SLT, OP_SLTU: alusel_o = SEL_ARITH;
            OP_MOVN, OP_MOVZ:                alusel_o = SEL_MOVE;
            default:                         alusel_o = SEL_NOP;
        endcase
    end

    // newest value wins: ex, then mem, then register file
    function automatic word_t fwd(input logic re, input reg_addr_t ra,
                                  input word_t rf_val, input word_t imm_val);
        return !re                             ? imm_val :
               (ex_we_i && ex_waddr_i == ra)   ? ex_wdata_i :
               (mem_we_i && mem_waddr_i == ra) ? mem_wdata_i : rf_val;
    endfunction

    always_comb begin
        opnd1_o = fwd(re1, rs, rf_rdata1_i, imm);
        opnd2_o = fwd(re2, rt, rf_rdata2_i, imm);
    end

    // movn/movz condition is on the forwarded rt
    assign move_ok = (aluop_o == OP_MOVN) ? (opnd2_o != '0) :
                     (aluop_o == OP_MOVZ) ? (opnd2_o == '0) : 1'b1;
    assign we_o    = (alusel_o != SEL_NOP) && move_ok && (waddr_o != '0);

    // r0 reads stay zero only if no forwarded write targets it
    a_no_r0_fwd: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ex_we_i && ex_waddr_i == '0) && !(mem_we_i && mem_waddr_i == '0));

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire core_ctrl_pkg::alu_op_e   aluop_i,
    input  wire core_ctrl_pkg::alu_sel_e  alusel_i,
    input  wire core_ctrl_pkg::word_t     opnd1_i,
    input  wire core_ctrl_pkg::word_t     opnd2_i,
    input  wire core_ctrl_pkg::reg_addr_t waddr_i,
    input  wire                           we_i,
    output logic                          ex_we_o,
    output core_ctrl_pkg::reg_addr_t      ex_waddr_o,
    output core_ctrl_pkg::word_t          ex_wdata_o
);
    import mips_isa_pkg::*;
    import core_ctrl_pkg::*;

    alu_op_e  aluop_q;
    alu_sel_e alusel_q;
    word_t    opnd1_q;
    word_t    opnd2_q;
    shamt_t   sh;
    word_t    logic_res;
    word_t    shift_res;
    word_t    arith_res;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_q    <= OP_NOP;
            alusel_q   <= SEL_NOP;
            opnd1_q    <= '0;
            opnd2_q    <= '0;
            ex_waddr_o <= '0;
            ex_we_o    <= 1'b0;
        end else begin
            aluop_q    <= aluop_i;
            alusel_q   <= alusel_i;
            opnd1_q    <= opnd1_i;
            opnd2_q    <= opnd2_i;
            ex_waddr_o <= waddr_i;
            ex_we_o    <= we_i;
        end
    end

    assign sh = opnd1_q[4:0];   // rt shifted by low bits of operand 1

    always_comb begin
        case (aluop_q)
            OP_AND:  logic_res = opnd1_q & opnd2_q;
            OP_XOR:  logic_res = opnd1_q ^ opnd2_q;
            OP_NOR:  logic_res = ~(opnd1_q | opnd2_q);
            default: logic_res = opnd1_q | opnd2_q;
        endcase
        case (aluop_q)
            OP_SRL:  shift_res = opnd2_q >> sh;
            OP_SRA:  shift_res = $signed(opnd2_q) >>> sh;
            default: shift_res = opnd2_q << sh;
        endcase
        case (aluop_q)
            OP_SUB:  arith_res = opnd1_q - opnd2_q;
            OP_SLT:  arith_res = word_t'($signed(opnd1_q) < $signed(opnd2_q));
            OP_SLTU: arith_res = word_t'(opnd1_q < opnd2_q);
            default: arith_res = opnd1_q + opnd2_q;
        endcase
    end

    always_comb begin
        case (alusel_q)
            SEL_LOGIC: ex_wdata_o = logic_res;
            SEL_SHIFT: ex_wdata_o = shift_res;
            SEL_ARITH: ex_wdata_o = arith_res;
            SEL_MOVE:  ex_wdata_o = opnd1_q;   // rs
            default:   ex_wdata_o = '0;
        endcase
    end

    // decode only raises a write for a known group
    a_we_has_group: assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_we_o |-> alusel_q != SEL_NOP);

endmodule

`default_nettype wire

// File: logic/retire_stage.sv
`default_nettype none

module retire_stage (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           ex_we_i,
    input  wire core_ctrl_pkg::reg_addr_t ex_waddr_i,
    input  wire core_ctrl_pkg::word_t     ex_wdata_i,
    output logic                          mem_we_o,
    output core_ctrl_pkg::reg_addr_t      mem_waddr_o,
    output core_ctrl_pkg::word_t          mem_wdata_o,
    output logic                          wb_we_o,
    output core_ctrl_pkg::reg_addr_t      wb_addr_o,
    output core_ctrl_pkg::word_t          wb_data_o
);

    // mem step carries results only, a load/store unit would sit between
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_we_o    <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            wb_we_o     <= 1'b0;
            wb_addr_o   <= '0;
            wb_data_o   <= '0;
        end else begin
            mem_we_o    <= ex_we_i;
            mem_waddr_o <= ex_waddr_i;
            mem_wdata_o <= ex_wdata_i;
            wb_we_o     <= mem_we_o;
            wb_addr_o   <= mem_waddr_o;
            wb_data_o   <= mem_wdata_o;
        end
    end

endmodule

`default_nettype wire

// File: logic/mini_core.sv
`default_nettype none

module mini_core (
    input  wire                      clk,
    input  wire                      arst_n_i,
    input  wire mips_isa_pkg::inst_t inst_i,
    output logic                     wb_we_o,
    output core_ctrl_pkg::reg_addr_t wb_addr_o,
    output core_ctrl_pkg::word_t     wb_data_o
);
    import core_ctrl_pkg::*;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    alu_op_e   aluop;
    alu_sel_e  alusel;
    word_t     opnd1;
    word_t     opnd2;
    reg_addr_t id_waddr;
    logic      id_we;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;

    decode_stage u_decode (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .inst_i      (inst_i),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .ex_we_i     (ex_we),
        .ex_waddr_i  (ex_waddr),
        .ex_wdata_i  (ex_wdata),
        .mem_we_i    (mem_we),
        .mem_waddr_i (mem_waddr),
        .mem_wdata_i (mem_wdata),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .aluop_o     (aluop),
        .alusel_o    (alusel),
        .opnd1_o     (opnd1),
        .opnd2_o     (opnd2),
        .waddr_o     (id_waddr),
        .we_o        (id_we)
    );

    execute_stage u_execute (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .aluop_i    (aluop),
        .alusel_i   (alusel),
        .opnd1_i    (opnd1),
        .opnd2_i    (opnd2),
        .waddr_i    (id_waddr),
        .we_i       (id_we),
        .ex_we_o    (ex_we),
        .ex_waddr_o (ex_waddr),
        .ex_wdata_o (ex_wdata)
    );

    retire_stage u_retire (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .ex_we_i     (ex_we),
        .ex_waddr_i  (ex_waddr),
        .ex_wdata_i  (ex_wdata),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .wb_we_o     (wb_we_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

endmodule

`default_nettype wire

// File: include/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// r-type word under OP_SPECIAL
function automatic inst_t enc_r(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
                                input reg_addr_t rd, input shamt_t sa);
    return {OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic inst_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                input imm16_t imm);
    return {op, rs, rt, imm};
endfunction

// returns 1 when the word writes a register
function automatic logic model_result(input inst_t iw, input word_t regs [NUM_REGS],
                                      output reg_addr_t wa, output word_t wd);
    word_t  s;
    word_t  t;
    word_t  si;
    shamt_t sh;
    logic   sh_imm;
    logic   ok;
    s      = regs[iw[25:21]];
    t      = regs[iw[20:16]];
    si     = {{16{iw[15]}}, iw[15:0]};
    sh_imm = iw[5:0] inside {FN_SLL, FN_SRL, FN_SRA};
    sh     = sh_imm ? iw[10:6] : s[4:0];
    wa     = iw[20:16];
    wd     = '0;
    ok     = 1'b1;
    case (iw[31:26])
        OP_ORI:            wd = s | {16'b0, iw[15:0]};
        OP_ANDI:           wd = s & {16'b0, iw[15:0]};
        OP_XORI:           wd = s ^ {16'b0, iw[15:0]};
        OP_LUI:            wd = {iw[15:0], 16'b0};
        OP_SLTI:           wd = word_t'($signed(s) < $signed(si));
        OP_SLTIU:          wd = word_t'(s < si);
        OP_ADDI, OP_ADDIU: wd = s + si;
        OP_SPECIAL: begin
            wa = iw[15:11];
            ok = sh_imm ? (iw[25:21] == '0) : (iw[10:6] == '0);
            case (iw[5:0])
                FN_SLL, FN_SLLV: wd = t << sh;
                FN_SRL, FN_SRLV: wd = t >> sh;
                FN_SRA, FN_SRAV: wd = $signed(t) >>> sh;
                FN_OR:           wd = s | t;
                FN_AND:          wd = s & t;
                FN_XOR:          wd = s ^ t;
                FN_NOR:          wd = ~(s | t);
                FN_ADD, FN_ADDU: wd = s + t;
                FN_SUB, FN_SUBU: wd = s - t;
                FN_SLT:          wd = word_t'($signed(s) < $signed(t));
                FN_SLTU:         wd = word_t'(s < t);
                FN_MOVN, FN_MOVZ: begin
                    ok = ok && ((t != '0) == (iw[5:0] == FN_MOVN));
                    wd = s;
                end
                default:         ok = 1'b0;
            endcase
        end
        default: ok = 1'b0;
    endcase
    return ok && (wa != '0);
endfunction

function automatic void model_commit(ref word_t regs [NUM_REGS], input logic we,
                                     input reg_addr_t wa, input word_t wd);
    if (we && wa != '0) begin
        regs[wa] = wd;
    end
endfunction

`endif

// File: testbench/tb_mini_core.sv
`default_nettype none

module tb_mini_core;
    import mips_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int NUM_INSTS = 2000;
    localparam int DRAIN_MAX = 10;

    localparam funct_t  LOGIC_FN [4]  = '{FN_OR, FN_AND, FN_XOR, FN_NOR};
    localparam opcode_t LOGIC_OP [4]  = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI};
    localparam funct_t  SHIFT_FN [3]  = '{FN_SLL, FN_SRL, FN_SRA};
    localparam funct_t  SHIFTV_FN [3] = '{FN_SLLV, FN_SRLV, FN_SRAV};
    localparam funct_t  ARITH_FN [6]  = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    localparam opcode_t ARITH_OP [4]  = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
    localparam funct_t  MOVE_FN [2]   = '{FN_MOVN, FN_MOVZ};

    typedef struct packed {
        logic      we;
        reg_addr_t wa;
        word_t     wd;
        int        idx;   // issue number, -1 for startup bubbles
    } expect_t;

    `include "core_model.svh"

    logic      clk;
    logic      arst_n;
    inst_t     inst;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;

    integer    seed;
    int        errors;
    int        checks;
    word_t     model_regs [NUM_REGS];
    expect_t   exp_q [$];

    mini_core uut (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .inst_i    (inst),
        .wb_we_o   (wb_we),
        .wb_addr_o (wb_addr),
        .wb_data_o (wb_data)
    );

    always #50 clk = ~clk;

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic inst_t random_inst();
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        imm16_t    imm;
        shamt_t    sa;
        inst_t     iw;
        rs  = reg_addr_t'(pick(8));   // r0..r7 keeps dependencies close
        rt  = reg_addr_t'(pick(8));
        rd  = reg_addr_t'(pick(8));
        imm = imm16_t'($random(seed));
        sa  = shamt_t'(pick(32));
        case (pick(13))
            0, 1:    iw = enc_r(LOGIC_FN[pick(4)], rs, rt, rd, '0);
            2, 3:    iw = enc_i(LOGIC_OP[pick(4)], rs, rt, imm);
            4:       iw = enc_r(SHIFT_FN[pick(3)], '0, rt, rd, sa);
            5:       iw = enc_r(SHIFTV_FN[pick(3)], rs, rt, rd, '0);
            6, 7:    iw = enc_r(ARITH_FN[pick(6)], rs, rt, rd, '0);
            8, 9:    iw = enc_i(ARITH_OP[pick(4)], rs, rt, imm);
            10:      iw = enc_r(MOVE_FN[pick(2)], rs, rt, rd, '0);
            11:      iw = '0;                        // bubble
            default: iw = inst_t'($random(seed));    // mostly unknown encodings
        endcase
        return iw;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // model result lands on the wb outputs 4 edges after the word is driven
    task automatic issue(input inst_t iw, input int idx);
        expect_t   e;
        reg_addr_t wa;
        word_t     wd;
        e.idx = idx;
        e.we  = model_result(iw, model_regs, wa, wd);
        e.wa  = wa;
        e.wd  = wd;
        model_commit(model_regs, e.we, wa, wd);
        exp_q.push_back(e);
        inst = iw;
    endtask

    task automatic compare_write();
        expect_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("expected-write queue ran empty while the pipeline was running");
        end else begin
            e = exp_q.pop_front();
            check_value($sformatf("wb_we #%0d", e.idx), word_t'(e.we), word_t'(wb_we));
            if (e.we) begin
                check_value($sformatf("wb_addr #%0d", e.idx), word_t'(e.wa), word_t'(wb_addr));
                check_value($sformatf("wb_data #%0d", e.idx), e.wd, wb_data);
            end
        end
    endtask

    initial begin
        int guard;
        clk    = 1'b0;
        arst_n = 1'b0;
        inst   = '0;
        seed   = 43;
        errors = 0;
        checks = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #10;
            check_value("wb_we in reset", '0, word_t'(wb_we));
        end
        arst_n = 1'b1;

        repeat (4) issue('0, -1);   // zero words already in the pipeline

        for (int n = 0; n < NUM_INSTS; n++) begin
            @(posedge clk);
            #10;
            compare_write();
            issue(random_inst(), n);
        end

        for (int n = 0; n < 5; n++) begin
            @(posedge clk);
            #10;
            compare_write();
            issue('0, NUM_INSTS + n);
        end

        guard = 0;
        while ((exp_q.size() > 0 || wb_we) && guard < DRAIN_MAX) begin
            @(posedge clk);
            #10;
            compare_write();
            guard++;
        end
        if (exp_q.size() > 0 || wb_we) begin
            errors++;
            $display("timeout: pipeline still busy, %0d expected writes left", exp_q.size());
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/mips_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/regfile.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/mini_core.sv
testbench/tb_mini_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_mini_core with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert -j 0 --top-module tb_mini_core -f list.f -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "^Everything OK$$" sim.log; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
